// ==== files.f ====
+incdir+hdl
hdl/axis_mm_pkg.sv
hdl/axis_fifo.sv
hdl/mac_q88.sv
hdl/matmul_core.sv
hdl/matmul_ctrl.sv
hdl/axis_top.sv
verification/clk_gen.sv
verification/tb_axis_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 --timescale 1ns/10ps --top-module tb_axis_top -f files.f
	out=$$(./obj_dir/Vtb_axis_top); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== verification/tb_axis_top.sv ====
// Testbench for the stream matrix multiplier with LFSR stimulus and a reference model
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module tb_axis_top
    import axis_mm_pkg::*;
();

    localparam int NUM_JOBS     = 8;
    localparam int NUM_BEATS    = NUM_JOBS * `AXIS_MM_DIM;
    localparam int RUN_LIMIT    = 20000;
    localparam int RESET_LIMIT  = 100;
    localparam int DRAIN_CYCLES = 40;
    localparam int STALL_FROM   = 450;  // Output held off across several job ends
    localparam int STALL_TO     = 800;

    logic aclk;
    logic aresetn;
    row_t s_axis_i_tdata;
    logic s_axis_i_tvalid;
    logic s_axis_i_tlast;
    logic s_axis_i_tready;
    row_t s_axis_w_tdata;
    logic s_axis_w_tvalid;
    logic s_axis_w_tlast;
    logic s_axis_w_tready;
    row_t m_axis_tdata;
    logic m_axis_tvalid;
    logic m_axis_tlast;
    logic m_axis_tready;

    logic [15:0] lfsr_state;
    row_t        a_beats [$];
    row_t        w_beats [$];
    row_t        exp_rows [$];  // Model output, one row per beat
    logic        exp_last [$];
    int          a_hold [NUM_JOBS];  // Extra delay before a job's first A beat
    int          w_hold [NUM_JOBS];

    clk_gen u_clk (.aclk(aclk), .aresetn(aresetn));

    axis_top i_dut (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tdata(s_axis_i_tdata), .s_axis_i_tvalid(s_axis_i_tvalid),
        .s_axis_i_tlast(s_axis_i_tlast), .s_axis_i_tready(s_axis_i_tready),
        .s_axis_w_tdata(s_axis_w_tdata), .s_axis_w_tvalid(s_axis_w_tvalid),
        .s_axis_w_tlast(s_axis_w_tlast), .s_axis_w_tready(s_axis_w_tready),
        .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast(m_axis_tlast), .m_axis_tready(m_axis_tready)
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic elem_t rand_elem(input logic full_range);
        logic [31:0] bits;
        elem_t       el;
        if (full_range)
        begin
            bits = rand_bits(16);
            el   = bits[15:0];
        end
        else
        begin
            bits = rand_bits(10);
            el   = {{6{bits[9]}}, bits[9:0]};  // Within +-2.0
        end
        return el;
    endfunction

    // Q16.16 sum back to Q8.8, floor shift then clamp
    function automatic elem_t shift_saturate(input longint sum);
        longint scaled;
        elem_t  el;
        scaled = sum >>> `AXIS_MM_FRAC;
        if (scaled > 32767)
            el = 16'sh7fff;
        else if (scaled < -32768)
            el = 16'sh8000;
        else
            el = scaled[15:0];
        return el;
    endfunction

    function automatic int beat_gap(input int idx, input logic weights);
        int gap;
        gap = int'(rand_bits(2));
        if ((idx % `AXIS_MM_DIM == 0) && (idx < NUM_BEATS))
            gap += weights ? w_hold[idx / `AXIS_MM_DIM] : a_hold[idx / `AXIS_MM_DIM];
        return gap;
    endfunction

    task automatic build_jobs();
        row_t        a_mat [`AXIS_MM_DIM];
        row_t        w_mat [`AXIS_MM_DIM];
        row_t        c_row;
        logic [31:0] bits;
        logic        full_range;
        longint      sum;
        for (int j = 0; j < NUM_JOBS; j++)
        begin
            bits       = rand_bits(1);
            full_range = (j == 1) || ((j > 1) && bits[0]);  // Job 0 small, job 1 full
            for (int r = 0; r < `AXIS_MM_DIM; r++)
                for (int k = 0; k < `AXIS_MM_DIM; k++)
                    a_mat[r][k] = rand_elem(full_range);
            for (int r = 0; r < `AXIS_MM_DIM; r++)
                for (int k = 0; k < `AXIS_MM_DIM; k++)
                    w_mat[r][k] = rand_elem(full_range);
            for (int r = 0; r < `AXIS_MM_DIM; r++)
            begin
                a_beats.push_back(a_mat[r]);
                w_beats.push_back(w_mat[r]);
                for (int c = 0; c < `AXIS_MM_DIM; c++)
                begin
                    sum = 0;
                    for (int k = 0; k < `AXIS_MM_DIM; k++)
                        sum += longint'(a_mat[r][k]) * longint'(w_mat[c][k]);
                    c_row[c] = shift_saturate(sum);  // C = A * W transposed
                end
                exp_rows.push_back(c_row);
                exp_last.push_back(r == `AXIS_MM_DIM - 1);
            end
        end
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_row(input row_t got, input row_t expected);
        if (got !== expected)
            abort_run($sformatf("** Error %0t ns: output row got %h expected %h",
                                $time, got, expected));
    endtask

    task automatic check_last(input logic got, input logic expected);
        if (got !== expected)
            abort_run($sformatf("** Error %0t ns: m_axis_tlast got %b expected %b",
                                $time, got, expected));
    endtask

    task automatic check_level(input logic got, input logic expected, input string what);
        if (got !== expected)
            abort_run($sformatf("** Error %0t ns: %s got %b expected %b",
                                $time, what, got, expected));
    endtask

    initial
    begin
        int          cycles;
        int          beats_seen;
        int          extra_beats;
        int          a_idx;
        int          w_idx;
        int          a_wait;
        int          w_wait;
        logic [31:0] bits;
        s_axis_i_tdata  = '0;
        s_axis_i_tvalid = 1'b0;
        s_axis_i_tlast  = 1'b0;
        s_axis_w_tdata  = '0;
        s_axis_w_tvalid = 1'b0;
        s_axis_w_tlast  = 1'b0;
        m_axis_tready   = 1'b0;
        lfsr_state      = 16'd91;
        for (int j = 0; j < NUM_JOBS; j++)
        begin
            a_hold[j] = 0;
            w_hold[j] = 0;
        end
        a_hold[1] = 150;  // Weights wait in their FIFO past the end of job 0
        w_hold[2] = 300;  // Inputs wait in their FIFO past the end of job 1
        build_jobs();

        cycles = 0;
        while ((aresetn !== 1'b1) && (cycles < RESET_LIMIT))
        begin
            @(posedge aclk);
            cycles++;
        end
        if (aresetn !== 1'b1)
            abort_run("Timeout waiting for reset to be released");
        check_level(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
        check_level(s_axis_i_tready, 1'b1, "s_axis_i_tready after reset");
        check_level(s_axis_w_tready, 1'b1, "s_axis_w_tready after reset");

        a_idx      = 0;
        w_idx      = 0;
        a_wait     = beat_gap(0, 1'b0);
        w_wait     = beat_gap(0, 1'b1);
        beats_seen = 0;
        cycles     = 0;
        while ((beats_seen < NUM_BEATS) && (cycles < RUN_LIMIT))
        begin
            @(posedge aclk);
            cycles++;
            if (m_axis_tvalid && m_axis_tready)
            begin
                check_row(m_axis_tdata, exp_rows.pop_front());
                check_last(m_axis_tlast, exp_last.pop_front());
                beats_seen++;
            end
            if (s_axis_i_tvalid && s_axis_i_tready)
            begin
                a_idx++;
                a_wait = beat_gap(a_idx, 1'b0);
            end
            if (!s_axis_i_tvalid || s_axis_i_tready)  // Hold a beat until taken
            begin
                if (a_wait > 0)
                begin
                    a_wait--;
                    s_axis_i_tvalid <= 1'b0;
                end
                else if (a_idx < NUM_BEATS)
                begin
                    s_axis_i_tvalid <= 1'b1;
                    s_axis_i_tdata  <= a_beats[a_idx];
                    s_axis_i_tlast  <= (a_idx % `AXIS_MM_DIM == `AXIS_MM_DIM - 1);
                end
                else
                    s_axis_i_tvalid <= 1'b0;
            end
            if (s_axis_w_tvalid && s_axis_w_tready)
            begin
                w_idx++;
                w_wait = beat_gap(w_idx, 1'b1);
            end
            if (!s_axis_w_tvalid || s_axis_w_tready)
            begin
                if (w_wait > 0)
                begin
                    w_wait--;
                    s_axis_w_tvalid <= 1'b0;
                end
                else if (w_idx < NUM_BEATS)
                begin
                    s_axis_w_tvalid <= 1'b1;
                    s_axis_w_tdata  <= w_beats[w_idx];
                    s_axis_w_tlast  <= (w_idx % `AXIS_MM_DIM == `AXIS_MM_DIM - 1);
                end
                else
                    s_axis_w_tvalid <= 1'b0;
            end
            bits = rand_bits(1);
            if ((cycles >= STALL_FROM) && (cycles < STALL_TO))
                m_axis_tready <= 1'b0;  // Output FIFO fills, controller waits for space
            else
                m_axis_tready <= bits[0];  // Random back-pressure
        end
        if (beats_seen < NUM_BEATS)
            abort_run($sformatf("Timeout waiting for result beats, %0d of %0d received",
                                beats_seen, NUM_BEATS));

        // Quiet period, no further beat may appear
        extra_beats = 0;
        m_axis_tready <= 1'b1;
        for (int i = 0; i < DRAIN_CYCLES; i++)
        begin
            @(posedge aclk);
            if (m_axis_tvalid && m_axis_tready)
                extra_beats++;
        end
        if (extra_beats == 0)
        begin
            $display("sim passed");
            $finish;
        end
        else
            abort_run($sformatf("Output stream sent %0d beats more than the jobs produce",
                                extra_beats));
    end

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
// Testbench clock of 10 ns period with a 16-cycle active-low reset
`timescale 1ns/10ps
`default_nettype none

module clk_gen
(
    output logic aclk,
    output logic aresetn
);

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;  // 10 ns period
    end

    initial
    begin
        aresetn = 1'b0;
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;  // Released on a rising edge
    end

endmodule

`default_nettype wire

// ==== hdl/axis_top.sv ====
// AXI-Stream matrix multiplier top with input, weight and output FIFOs
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module axis_top
    import axis_mm_pkg::*;
(
    input  logic aclk,
    input  logic aresetn,
    input  row_t s_axis_i_tdata,
    input  logic s_axis_i_tvalid,
    input  logic s_axis_i_tlast,
    output logic s_axis_i_tready,
    input  row_t s_axis_w_tdata,
    input  logic s_axis_w_tvalid,
    input  logic s_axis_w_tlast,
    output logic s_axis_w_tready,
    output row_t m_axis_tdata,
    output logic m_axis_tvalid,
    output logic m_axis_tlast,
    input  logic m_axis_tready
);

    row_t                                     i_head;
    row_t                                     w_head;
    logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] i_count;
    logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] w_count;
    logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] o_count;
    logic                                     i_pop;
    logic                                     w_pop;
    logic                                     wr_en;
    logic [1:0]                               wr_addr;
    logic                                     start;
    logic                                     done;
    logic [1:0]                               rd_addr;
    row_t                                     rd_row;
    logic                                     o_valid;
    logic                                     o_last;
    row_t                                     o_data;

    axis_fifo #(.DEPTH(`AXIS_MM_FIFO_DEPTH)) u_in_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .s_data(s_axis_i_tdata), .s_valid(s_axis_i_tvalid),
        .s_last(s_axis_i_tlast), .s_ready(s_axis_i_tready),
        .m_data(i_head), .m_valid(), .m_last(), .m_ready(i_pop),  // Count gates the pops
        .count(i_count)
    );

    axis_fifo #(.DEPTH(`AXIS_MM_FIFO_DEPTH)) u_wt_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .s_data(s_axis_w_tdata), .s_valid(s_axis_w_tvalid),
        .s_last(s_axis_w_tlast), .s_ready(s_axis_w_tready),
        .m_data(w_head), .m_valid(), .m_last(), .m_ready(w_pop),
        .count(w_count)
    );

    matmul_ctrl u_ctrl (
        .aclk(aclk), .aresetn(aresetn),
        .i_count(i_count), .w_count(w_count), .i_pop(i_pop), .w_pop(w_pop),
        .wr_en(wr_en), .wr_addr(wr_addr), .start(start), .done(done),
        .rd_addr(rd_addr), .rd_row(rd_row), .o_count(o_count),
        .o_valid(o_valid), .o_last(o_last), .o_data(o_data)
    );

    matmul_core u_core (
        .aclk(aclk), .aresetn(aresetn), .start(start), .done(done),
        .wr_en(wr_en), .wr_addr(wr_addr), .a_row(i_head), .w_row(w_head),
        .rd_addr(rd_addr), .rd_row(rd_row)
    );

    // Controller checks free space before each job, so write ready stays open
    axis_fifo #(.DEPTH(`AXIS_MM_FIFO_DEPTH)) u_out_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .s_data(o_data), .s_valid(o_valid), .s_last(o_last), .s_ready(),
        .m_data(m_axis_tdata), .m_valid(m_axis_tvalid),
        .m_last(m_axis_tlast), .m_ready(m_axis_tready),
        .count(o_count)
    );

endmodule

`default_nettype wire

// ==== hdl/matmul_ctrl.sv ====
// Control FSM that loads the core from the input FIFOs and drains C to the output FIFO
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module matmul_ctrl
    import axis_mm_pkg::*;
(
    input  logic                                     aclk,
    input  logic                                     aresetn,
    input  logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] i_count,
    input  logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] w_count,
    output logic                                     i_pop,
    output logic                                     w_pop,
    output logic                                     wr_en,
    output logic [1:0]                               wr_addr,
    output logic                                     start,
    input  logic                                     done,
    output logic [1:0]                               rd_addr,
    input  row_t                                     rd_row,
    input  logic [$clog2(`AXIS_MM_FIFO_DEPTH+1)-1:0] o_count,
    output logic                                     o_valid,
    output logic                                     o_last,
    output row_t                                     o_data
);

    ctrl_state_t state_reg;
    ctrl_state_t state_next;
    logic [1:0]  row_cnt_reg;   // Shared by load and read
    logic [1:0]  row_cnt_next;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_reg   <= ST_IDLE;
            row_cnt_reg <= '0;
            o_valid     <= 1'b0;
            o_last      <= 1'b0;
        end
        else
        begin
            state_reg   <= state_next;
            row_cnt_reg <= row_cnt_next;
            o_valid     <= (state_reg == ST_READ);
            o_last      <= (state_reg == ST_READ) && (row_cnt_reg == 2'(`AXIS_MM_DIM - 1));
        end
    end

    always_ff @(posedge aclk)
    begin
        o_data <= rd_row;  // Lines up with the registered valid
    end

    always_comb
    begin
        state_next   = state_reg;
        row_cnt_next = row_cnt_reg;
        case (state_reg)
            ST_IDLE:
            begin
                // Both FIFOs hold a whole matrix
                if ((i_count >= `AXIS_MM_DIM) && (w_count >= `AXIS_MM_DIM))
                    state_next = ST_LOAD;
            end
            ST_LOAD, ST_READ:
            begin
                row_cnt_next = row_cnt_reg + 2'd1;
                if (row_cnt_reg == 2'(`AXIS_MM_DIM - 1))
                    state_next = (state_reg == ST_LOAD) ? ST_START : ST_IDLE;
            end
            ST_START: state_next = ST_WAIT;
            ST_WAIT:
            begin
                if (done && (o_count <= `AXIS_MM_FIFO_DEPTH - `AXIS_MM_DIM))
                    state_next = ST_READ;  // Four pushes cannot be refused
            end
            default: state_next = ST_IDLE;
        endcase
    end

    assign i_pop   = (state_reg == ST_LOAD);
    assign w_pop   = (state_reg == ST_LOAD);
    assign wr_en   = (state_reg == ST_LOAD);
    assign wr_addr = row_cnt_reg;
    assign start   = (state_reg == ST_START);
    assign rd_addr = row_cnt_reg;

endmodule

`default_nettype wire

// ==== hdl/matmul_core.sv ====
// Matrix core computing C = A * W transposed with one sequential MAC
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module matmul_core
    import axis_mm_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       start,
    output logic       done,
    input  logic       wr_en,
    input  logic [1:0] wr_addr,
    input  row_t       a_row,
    input  row_t       w_row,
    input  logic [1:0] rd_addr,
    output row_t       rd_row
);

    row_t        a_buf [`AXIS_MM_DIM];
    row_t        w_buf [`AXIS_MM_DIM];
    row_t        c_buf [`AXIS_MM_DIM];
    core_state_t state;
    logic [1:0]  r;            // Row of A and C
    logic [1:0]  c;            // Row of W, column of C
    logic [1:0]  k;            // Inner index
    logic        mac_en;
    logic        mac_clear;
    elem_t       mac_result;

    assign done      = (state == CS_DONE);  // Held until the next start
    assign mac_en    = (state == CS_MAC);
    assign mac_clear = (state == CS_STORE);
    assign rd_row    = c_buf[rd_addr];

    mac_q88 u_mac (
        .aclk    (aclk),
        .aresetn (aresetn),
        .clear   (mac_clear),
        .en      (mac_en),
        .a       (a_buf[r][k]),
        .b       (w_buf[c][k]),
        .result  (mac_result)
    );

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= CS_IDLE;
            r     <= '0;
            c     <= '0;
            k     <= '0;
        end
        else
        begin
            case (state)
                CS_IDLE, CS_DONE:
                begin
                    if (start)
                    begin
                        state <= CS_MAC;
                        r     <= '0;
                        c     <= '0;
                        k     <= '0;
                    end
                end
                CS_MAC:
                begin
                    k <= k + 2'd1;
                    if (k == 2'(`AXIS_MM_DIM - 1))
                        state <= CS_STORE;
                end
                CS_STORE:
                begin
                    k     <= '0;
                    state <= CS_MAC;
                    if (c == 2'(`AXIS_MM_DIM - 1))
                    begin
                        c <= '0;
                        if (r == 2'(`AXIS_MM_DIM - 1))
                            state <= CS_DONE;  // Last element written
                        else
                            r <= r + 2'd1;
                    end
                    else
                        c <= c + 2'd1;
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    // Operand buffers and result file
    always_ff @(posedge aclk)
    begin
        if (wr_en)
        begin
            a_buf[wr_addr] <= a_row;
            w_buf[wr_addr] <= w_row;
        end
        if (state == CS_STORE)
            c_buf[r][c] <= mac_result;
    end

endmodule

`default_nettype wire

// ==== hdl/mac_q88.sv ====
// Q8.8 multiply-accumulate with clear and a shifted, saturated result
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module mac_q88
    import axis_mm_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  clear,
    input  logic  en,
    input  elem_t a,
    input  elem_t b,
    output elem_t result
);

    logic signed [35:0] acc;     // Q20.16, headroom for four products
    logic signed [31:0] product; // Full precision Q16.16
    logic signed [35:0] scaled;

    assign product = a * b;
    assign scaled  = acc >>> `AXIS_MM_FRAC;  // Rounds toward minus infinity

    always_ff @(posedge aclk)
    begin
        if (!aresetn || clear)
            acc <= '0;
        else if (en)
            acc <= acc + 36'(product);
    end

    always_comb
    begin
        if (scaled > 36'sd32767)
            result = 16'sh7fff;
        else if (scaled < -36'sd32768)
            result = 16'sh8000;
        else
            result = scaled[15:0];
    end

endmodule

`default_nettype wire

// ==== hdl/axis_fifo.sv ====
// Synchronous first-word-fall-through stream FIFO with fill count
`timescale 1ns/10ps
`default_nettype none

`include "axis_mm_defs.svh"

module axis_fifo
    import axis_mm_pkg::*;
#(
    parameter int DEPTH = `AXIS_MM_FIFO_DEPTH
)
(
    input  logic                         aclk,
    input  logic                         aresetn,
    input  row_t                         s_data,
    input  logic                         s_valid,
    input  logic                         s_last,
    output logic                         s_ready,
    output row_t                         m_data,
    output logic                         m_valid,
    output logic                         m_last,
    input  logic                         m_ready,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    row_t             data_mem [DEPTH];
    logic             last_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign s_ready = (count != DEPTH);
    assign m_valid = (count != 0);
    assign m_data  = data_mem[rd_ptr];  // Head row visible without a read cycle
    assign m_last  = last_mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            data_mem[wr_ptr] <= s_data;
            last_mem[wr_ptr] <= s_last;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axis_mm_pkg.sv ====
// Shared element, row and state types of the matrix multiplier front end
`default_nettype none

`include "axis_mm_defs.svh"

package axis_mm_pkg;

    typedef logic signed [`AXIS_MM_ELEM_W-1:0] elem_t;   // Signed Q8.8

    typedef elem_t [`AXIS_MM_DIM-1:0] row_t;             // Element 0 in low bits

    // Controller sequence
    typedef enum logic [2:0] {
        ST_IDLE,    // Wait for a full A and W
        ST_LOAD,    // Copy rows into core buffers
        ST_START,   // One-cycle start pulse
        ST_WAIT,    // Wait for done and output space
        ST_READ     // Push C rows to output FIFO
    } ctrl_state_t;

    typedef enum logic [1:0] {CS_IDLE, CS_MAC, CS_STORE, CS_DONE} core_state_t;

endpackage

`default_nettype wire

// ==== hdl/axis_mm_defs.svh ====
// Matrix multiplier macros for dimension, Q8.8 format and stream FIFO depth
`ifndef AXIS_MM_DEFS_SVH
`define AXIS_MM_DEFS_SVH

// Matrix side, also elements per row and beats per matrix
`define AXIS_MM_DIM 4

// Fraction bits of a Q8.8 element
`define AXIS_MM_FRAC 8

// Element width in bits
`define AXIS_MM_ELEM_W 16

// Room for two matrices in every stream FIFO
`define AXIS_MM_FIFO_DEPTH 8

`endif
